// File: flist.f
rv_isa_pkg.sv
hart_pkg.sv
pipe_ctrl_if.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
mem_stage.sv
writeback_stage.sv
hart.sv
tb_hart.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_hart -f flist.f -o tb_hart
./obj_dir/tb_hart

// File: tb_hart.sv
`timescale 1ns/1ns

module tb_hart;
  import hart_pkg::*;
  import rv_isa_pkg::*;

  localparam word_t      RESET_ADDR  = 32'h0000_0100;
  localparam int         NUM_TESTS   = 4;
  localparam int         TEST_CYCLES = 200;
  localparam logic [2:0] F3_WORD     = 3'b010;
  localparam word_t      NOP         = 32'h0000_0013;

  logic      i_clk;
  logic      i_rst;
  logic      i_dmem_ready;
  logic      i_dmem_valid;
  word_t     i_dmem_rdata;
  word_t     o_imem_raddr;
  word_t     o_dmem_addr;
  logic      o_dmem_ren;
  logic      o_dmem_wen;
  word_t     o_dmem_wdata;
  logic      o_retire_valid;
  word_t     o_retire_inst;
  word_t     o_retire_pc;
  reg_addr_t o_retire_rd_waddr;
  word_t     o_retire_rd_wdata;
  logic      o_retire_halt;

  word_t rom [0:63];
  word_t dmem [0:255];
  int    prog_len;
  // expected retire records, one entry per instruction in program order
  word_t exp_pc [$];
  word_t exp_inst [$];
  word_t exp_rd [$];
  word_t exp_data [$];

  hart #(.RESET_ADDR(RESET_ADDR)) uut (
    .i_clk(i_clk), .i_rst(i_rst), .o_imem_raddr(o_imem_raddr),
    .i_imem_rdata(rom[6'((o_imem_raddr - RESET_ADDR) >> 2)]),
    .i_dmem_ready(i_dmem_ready), .i_dmem_valid(i_dmem_valid), .i_dmem_rdata(i_dmem_rdata),
    .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
    .o_dmem_wdata(o_dmem_wdata), .o_retire_valid(o_retire_valid),
    .o_retire_inst(o_retire_inst), .o_retire_pc(o_retire_pc),
    .o_retire_rd_waddr(o_retire_rd_waddr), .o_retire_rd_wdata(o_retire_rd_wdata),
    .o_retire_halt(o_retire_halt)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  // the whole run gets a fixed budget of cycles per test plus its reset
  initial begin
    #(NUM_TESTS * (TEST_CYCLES + 10) * 10);
    fail_run("watchdog expired before all tests finished");
  end

  // data memory with a random wait before ready and again before valid
  initial begin
    int    wait_left;
    int    data_wait;
    int    phase;
    word_t load_addr;
    i_dmem_ready = 1'b0;
    i_dmem_valid = 1'b0;
    i_dmem_rdata = '0;
    void'($urandom(32'hafa9_ef64));
    wait_left = -1;
    data_wait = 0;
    phase = 0;
    load_addr = '0;
    forever begin
      @(negedge i_clk);
      i_dmem_ready = 1'b0;
      i_dmem_valid = 1'b0;
      if (i_rst) begin
        phase = 0;
        wait_left = -1;
      end else if (phase == 0 && (o_dmem_ren || o_dmem_wen)) begin
        if (wait_left < 0) wait_left = int'($urandom % 4);
        if (wait_left == 0) begin
          i_dmem_ready = 1'b1;
          wait_left = -1;
          if (o_dmem_wen) begin
            dmem[o_dmem_addr[9:2]] = o_dmem_wdata;
          end else begin
            load_addr = o_dmem_addr;
            data_wait = int'($urandom % 4);
            // with no wait the data comes back in the accepting cycle itself
            if (data_wait == 0) begin
              i_dmem_valid = 1'b1;
              i_dmem_rdata = dmem[load_addr[9:2]];
            end else begin
              phase = 1;
            end
          end
        end else begin
          wait_left--;
        end
      end else if (phase == 1) begin
        data_wait--;
        if (data_wait == 0) begin
          i_dmem_valid = 1'b1;
          i_dmem_rdata = dmem[load_addr[9:2]];
          phase = 0;
        end
      end
    end
  end

  function automatic word_t r_type(logic f7alt, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {1'b0, f7alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t sw_inst(logic [11:0] off, reg_addr_t rs2, reg_addr_t rs1);
    return {off[11:5], rs2, rs1, F3_WORD, off[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  // appends one instruction and the record it should retire with
  task automatic emit(input word_t inst, input logic retires, input reg_addr_t rd,
                      input word_t data);
    if (retires) begin
      exp_pc.push_back(RESET_ADDR + 32'(prog_len * 4));
      exp_inst.push_back(inst);
      exp_rd.push_back({27'd0, rd});
      exp_data.push_back(data);
    end
    rom[prog_len] = inst;
    prog_len++;
  endtask

  task automatic new_program();
    for (int i = 0; i < 64; i++) rom[i] = NOP;
    prog_len = 0;
    exp_pc.delete();
    exp_inst.delete();
    exp_rd.delete();
    exp_data.delete();
  endtask

  // nothing may retire or touch memory while reset is held
  task automatic reset_dut();
    @(negedge i_clk);
    i_rst = 1'b1;
    repeat (8) begin
      @(negedge i_clk);
      check("o_retire_valid", {31'd0, o_retire_valid}, 32'd0);
      check("o_dmem_ren", {31'd0, o_dmem_ren}, 32'd0);
      check("o_dmem_wen", {31'd0, o_dmem_wen}, 32'd0);
      check("o_imem_raddr", o_imem_raddr, RESET_ADDR);
    end
    i_rst = 1'b0;
    // the back of the pipe is still empty in the first cycle out of reset
    @(negedge i_clk);
    check("o_retire_valid", {31'd0, o_retire_valid}, 32'd0);
    check("o_dmem_ren", {31'd0, o_dmem_ren}, 32'd0);
    check("o_dmem_wen", {31'd0, o_dmem_wen}, 32'd0);
  endtask

  task automatic run_program();
    int n;
    n = 0;
    reset_dut();
    forever begin
      @(negedge i_clk);
      if (o_retire_valid) begin
        if (n >= exp_pc.size()) fail_run("an instruction retired that should not have");
        check("o_retire_pc", o_retire_pc, exp_pc[n]);
        check("o_retire_inst", o_retire_inst, exp_inst[n]);
        check("o_retire_rd_waddr", {27'd0, o_retire_rd_waddr}, exp_rd[n]);
        // the written value only means something when a register is written
        if (exp_rd[n] != 0) check("o_retire_rd_wdata", o_retire_rd_wdata, exp_data[n]);
        check("o_retire_halt", {31'd0, o_retire_halt}, {31'd0, exp_inst[n] == EBREAK_INST});
        n++;
        if (o_retire_halt) break;
      end
    end
    check("retire count", 32'(n), 32'(exp_pc.size()));
  endtask

  task automatic reset_then_halt();
    new_program();
    emit(EBREAK_INST, 1'b1, 5'd0, '0);
    run_program();
  endtask

  task automatic alu_dependency_chain();
    new_program();
    emit({20'h12345, 5'd1, 7'b0110111}, 1'b1, 5'd1, 32'h1234_5000);
    emit(i_type(12'h678, 5'd1, F3_ADD_SUB, 5'd2, 7'b0010011), 1'b1, 5'd2, 32'h1234_5678);
    emit(r_type(1'b0, 5'd1, 5'd2, F3_ADD_SUB, 5'd3), 1'b1, 5'd3, 32'h2468_a678);
    emit(r_type(1'b1, 5'd2, 5'd3, F3_ADD_SUB, 5'd4), 1'b1, 5'd4, 32'h1234_5000);
    emit(i_type(12'hfff, 5'd4, F3_XOR, 5'd5, 7'b0010011), 1'b1, 5'd5, 32'hedcb_afff);
    emit(i_type(12'h404, 5'd5, F3_SRL_SRA, 5'd6, 7'b0010011), 1'b1, 5'd6, 32'hfedc_baff);
    emit(i_type(12'h004, 5'd5, F3_SRL_SRA, 5'd7, 7'b0010011), 1'b1, 5'd7, 32'h0edc_baff);
    emit(r_type(1'b0, 5'd7, 5'd6, F3_SLT, 5'd8), 1'b1, 5'd8, 32'd1);
    emit(r_type(1'b0, 5'd7, 5'd6, F3_SLTU, 5'd9), 1'b1, 5'd9, 32'd0);
    emit(i_type(12'h01f, 5'd8, F3_SLL, 5'd10, 7'b0010011), 1'b1, 5'd10, 32'h8000_0000);
    emit(r_type(1'b0, 5'd3, 5'd10, F3_OR, 5'd11), 1'b1, 5'd11, 32'ha468_a678);
    emit(r_type(1'b0, 5'd5, 5'd11, F3_AND, 5'd12), 1'b1, 5'd12, 32'ha448_a678);
    emit(EBREAK_INST, 1'b1, 5'd0, '0);
    run_program();
  endtask

  task automatic stores_then_loads();
    new_program();
    emit(i_type(12'h040, 5'd0, F3_ADD_SUB, 5'd1, 7'b0010011), 1'b1, 5'd1, 32'h40);
    emit({20'hcafe0, 5'd2, 7'b0110111}, 1'b1, 5'd2, 32'hcafe_0000);
    emit(i_type(12'h123, 5'd2, F3_ADD_SUB, 5'd2, 7'b0010011), 1'b1, 5'd2, 32'hcafe_0123);
    emit(sw_inst(12'd0, 5'd2, 5'd1), 1'b1, 5'd0, '0);
    emit(i_type(12'h055, 5'd0, F3_ADD_SUB, 5'd3, 7'b0010011), 1'b1, 5'd3, 32'h55);
    emit(sw_inst(12'd4, 5'd3, 5'd1), 1'b1, 5'd0, '0);
    emit(i_type(12'd0, 5'd1, F3_WORD, 5'd4, 7'b0000011), 1'b1, 5'd4, 32'hcafe_0123);
    // this add needs the load just ahead of it
    emit(r_type(1'b0, 5'd3, 5'd4, F3_ADD_SUB, 5'd5), 1'b1, 5'd5, 32'hcafe_0178);
    emit(i_type(12'd4, 5'd1, F3_WORD, 5'd6, 7'b0000011), 1'b1, 5'd6, 32'h55);
    emit(sw_inst(12'd8, 5'd5, 5'd1), 1'b1, 5'd0, '0);
    emit(i_type(12'd8, 5'd1, F3_WORD, 5'd7, 7'b0000011), 1'b1, 5'd7, 32'hcafe_0178);
    emit(r_type(1'b1, 5'd6, 5'd7, F3_ADD_SUB, 5'd8), 1'b1, 5'd8, 32'hcafe_0123);
    emit(EBREAK_INST, 1'b1, 5'd0, '0);
    run_program();
    // the three stores land at byte addresses 0x40, 0x44 and 0x48
    check("dmem[0x40]", dmem[16], 32'hcafe_0123);
    check("dmem[0x44]", dmem[17], 32'h0000_0055);
    check("dmem[0x48]", dmem[18], 32'hcafe_0178);
  endtask

  task automatic branch_sequence();
    new_program();
    emit(i_type(12'd5, 5'd0, F3_ADD_SUB, 5'd1, 7'b0010011), 1'b1, 5'd1, 32'd5);
    emit(i_type(12'hffd, 5'd0, F3_ADD_SUB, 5'd2, 7'b0010011), 1'b1, 5'd2, 32'hffff_fffd);
    emit(b_type(13'd8, 5'd2, 5'd1, F3_BEQ), 1'b1, 5'd0, '0);
    emit(b_type(13'd12, 5'd1, 5'd2, F3_BLT), 1'b1, 5'd0, '0);
    emit(i_type(12'd1, 5'd0, F3_ADD_SUB, 5'd3, 7'b0010011), 1'b0, 5'd3, '0);
    emit(i_type(12'd2, 5'd0, F3_ADD_SUB, 5'd3, 7'b0010011), 1'b0, 5'd3, '0);
    emit(b_type(13'd8, 5'd1, 5'd2, F3_BLTU), 1'b1, 5'd0, '0);
    emit(b_type(13'd12, 5'd2, 5'd1, F3_BNE), 1'b1, 5'd0, '0);
    emit(i_type(12'd7, 5'd0, F3_ADD_SUB, 5'd4, 7'b0010011), 1'b0, 5'd4, '0);
    emit(i_type(12'd8, 5'd0, F3_ADD_SUB, 5'd4, 7'b0010011), 1'b0, 5'd4, '0);
    emit(b_type(13'd8, 5'd1, 5'd2, F3_BGEU), 1'b1, 5'd0, '0);
    emit(i_type(12'd9, 5'd0, F3_ADD_SUB, 5'd5, 7'b0010011), 1'b0, 5'd5, '0);
    emit(b_type(13'd8, 5'd2, 5'd1, F3_BGE), 1'b1, 5'd0, '0);
    emit(i_type(12'd1, 5'd0, F3_ADD_SUB, 5'd6, 7'b0010011), 1'b0, 5'd6, '0);
    emit(i_type(12'd1, 5'd1, F3_ADD_SUB, 5'd7, 7'b0010011), 1'b1, 5'd7, 32'd6);
    emit(EBREAK_INST, 1'b1, 5'd0, '0);
    run_program();
  endtask

  initial begin
    i_rst = 1'b1;
    // every word starts out tagged with its own byte address
    for (int i = 0; i < 256; i++) dmem[i] = 32'h5a00_0000 | 32'(i * 4);
    new_program();
    reset_then_halt();
    alu_dependency_chain();
    stores_then_loads();
    branch_sequence();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: hart.sv
`timescale 1ns/1ns

module hart #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic                i_clk,
  input  logic                i_rst,
  output hart_pkg::word_t     o_imem_raddr,
  input  hart_pkg::word_t     i_imem_rdata,
  input  logic                i_dmem_ready,
  input  logic                i_dmem_valid,
  input  hart_pkg::word_t     i_dmem_rdata,
  output hart_pkg::word_t     o_dmem_addr,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  output hart_pkg::word_t     o_dmem_wdata,
  output logic                o_retire_valid,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output logic                o_retire_halt
);
  import hart_pkg::*;

  if_id_t    if_d;
  if_id_t    if_q;
  id_ex_t    id_d;
  id_ex_t    id_q;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  logic      wb_wen;
  reg_addr_t wb_rd;
  word_t     wb_data;

  pipe_ctrl_if ctrl ();

  fetch_stage #(.RESET_ADDR(RESET_ADDR)) u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .ctrl         (ctrl.fetch),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_if         (if_d)
  );

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_hold  (ctrl.hold_front),
    .i_flush (ctrl.flush_front),
    .i_d     (if_d),
    .o_q     (if_q)
  );

  decode_stage u_decode (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_if      (if_q),
    .i_wb_wen  (wb_wen),
    .i_wb_rd   (wb_rd),
    .i_wb_data (wb_data),
    .o_id      (id_d)
  );

  hazard_unit u_hazard (
    .i_if    (if_q),
    .i_id_ex (id_q),
    .ctrl    (ctrl.hazard)
  );

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_hold  (ctrl.hold_back),
    .i_flush (ctrl.flush_decode),
    .i_d     (id_d),
    .o_q     (id_q)
  );

  execute_stage u_execute (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_id_ex   (id_q),
    .i_wb_wen  (wb_wen),
    .i_wb_rd   (wb_rd),
    .i_wb_data (wb_data),
    .ctrl      (ctrl.execute),
    .o_ex_mem  (ex_mem)
  );

  mem_stage u_mem (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ex_mem     (ex_mem),
    .ctrl         (ctrl.memory),
    .i_dmem_ready (i_dmem_ready),
    .i_dmem_valid (i_dmem_valid),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_ren   (o_dmem_ren),
    .o_dmem_wen   (o_dmem_wen),
    .o_dmem_wdata (o_dmem_wdata),
    .o_mem_wb     (mem_wb)
  );

  writeback_stage u_writeback (
    .i_mem_wb          (mem_wb),
    .o_wb_wen          (wb_wen),
    .o_wb_rd           (wb_rd),
    .o_wb_data         (wb_data),
    .o_retire_valid    (o_retire_valid),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_rd_waddr (o_retire_rd_waddr),
    .o_retire_rd_wdata (o_retire_rd_wdata),
    .o_retire_halt     (o_retire_halt)
  );

endmodule

// File: writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
  input  hart_pkg::mem_wb_t   i_mem_wb,
  output logic                o_wb_wen,
  output hart_pkg::reg_addr_t o_wb_rd,
  output hart_pkg::word_t     o_wb_data,
  output logic                o_retire_valid,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output logic                o_retire_halt
);
  import hart_pkg::*;
  import rv_isa_pkg::*;

  word_t wb_data;

  assign wb_data = (i_mem_wb.wb_src == WB_LOAD) ? i_mem_wb.load_data : i_mem_wb.alu_result;

  // rd arrives already zeroed for stores, branches and ebreak
  assign o_wb_wen  = i_mem_wb.valid && i_mem_wb.rd != '0;
  assign o_wb_rd   = i_mem_wb.rd;
  assign o_wb_data = wb_data;

  // every valid MEM/WB entry retires exactly once, bubbles never do
  assign o_retire_valid    = i_mem_wb.valid;
  assign o_retire_inst     = i_mem_wb.inst;
  assign o_retire_pc       = i_mem_wb.pc;
  assign o_retire_rd_waddr = i_mem_wb.rd;
  assign o_retire_rd_wdata = wb_data;
  assign o_retire_halt     = i_mem_wb.valid && i_mem_wb.inst == EBREAK_INST;

endmodule

// File: mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
  input  logic              i_clk,
  input  logic              i_rst,
  input  hart_pkg::ex_mem_t i_ex_mem,
  pipe_ctrl_if.memory       ctrl,
  input  logic              i_dmem_ready,
  input  logic              i_dmem_valid,
  input  hart_pkg::word_t   i_dmem_rdata,
  output hart_pkg::word_t   o_dmem_addr,
  output logic              o_dmem_ren,
  output logic              o_dmem_wen,
  output hart_pkg::word_t   o_dmem_wdata,
  output hart_pkg::mem_wb_t o_mem_wb
);
  import hart_pkg::*;

  logic    accepted_q;
  logic    req;
  logic    done;
  logic    busy;
  mem_wb_t wb_next;

  // once a load is accepted ren drops, otherwise memory would see a second read
  assign o_dmem_ren   = i_ex_mem.valid && i_ex_mem.mem_ren && !accepted_q;
  assign o_dmem_wen   = i_ex_mem.valid && i_ex_mem.mem_wen;
  assign o_dmem_addr  = i_ex_mem.alu_result;
  assign o_dmem_wdata = i_ex_mem.store_data;
  assign req          = o_dmem_ren || o_dmem_wen;

  // a store is finished at acceptance, a load when its data turns valid
  assign done = o_dmem_wen ? i_dmem_ready :
                i_ex_mem.valid && i_ex_mem.mem_ren && (accepted_q || i_dmem_ready) &&
                i_dmem_valid;
  assign busy = i_ex_mem.valid && (i_ex_mem.mem_ren || i_ex_mem.mem_wen) && !done;
  assign ctrl.mem_busy = busy;

  always_ff @(posedge i_clk) begin
    if (i_rst || done) begin
      accepted_q <= 1'b0;
    end else if (req && i_dmem_ready) begin
      accepted_q <= 1'b1;
    end
  end

  always_comb begin
    wb_next.inst       = i_ex_mem.inst;
    wb_next.pc         = i_ex_mem.pc;
    wb_next.valid      = i_ex_mem.valid;
    wb_next.alu_result = i_ex_mem.alu_result;
    wb_next.load_data  = i_dmem_rdata;
    wb_next.wb_src     = i_ex_mem.wb_src;
    wb_next.rd         = i_ex_mem.rd;
  end

  // the instruction stays in EX/MEM while busy, so MEM/WB takes a bubble instead
  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_hold  (1'b0),
    .i_flush (busy),
    .i_d     (wb_next),
    .o_q     (o_mem_wb)
  );

  // the stall of the upstream stages must keep an open request steady
  a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (req && !i_dmem_ready) |=> ($stable(o_dmem_addr) && $stable(o_dmem_ren) &&
                                $stable(o_dmem_wen) && $stable(o_dmem_wdata)));

  a_ren_wen_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_dmem_ren && o_dmem_wen));

endmodule

// File: execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::id_ex_t    i_id_ex,
  input  logic                i_wb_wen,
  input  hart_pkg::reg_addr_t i_wb_rd,
  input  hart_pkg::word_t     i_wb_data,
  pipe_ctrl_if.execute        ctrl,
  output hart_pkg::ex_mem_t   o_ex_mem
);
  import hart_pkg::*;
  import rv_isa_pkg::*;

  word_t   fwd_a;
  word_t   fwd_b;
  word_t   held_a;
  word_t   held_b;
  logic    stalled_q;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_b;
  word_t   alu_y;
  logic    cond;
  ex_mem_t ex_next;

  // EX/MEM is the younger producer, so its match is applied last and wins
  function automatic word_t forward(reg_addr_t rs, word_t reg_val, ex_mem_t mem_q,
                                    logic wb_wen, reg_addr_t wb_rd, word_t wb_data);
    word_t val;
    val = reg_val;
    if (wb_wen && wb_rd != '0 && wb_rd == rs) begin
      val = wb_data;
    end
    if (mem_q.valid && mem_q.wb_src == WB_ALU && mem_q.rd != '0 && mem_q.rd == rs) begin
      val = mem_q.alu_result;
    end
    return val;
  endfunction

  assign fwd_a = forward(i_id_ex.rs1, i_id_ex.rs1_val, o_ex_mem, i_wb_wen, i_wb_rd, i_wb_data);
  assign fwd_b = forward(i_id_ex.rs2, i_id_ex.rs2_val, o_ex_mem, i_wb_wen, i_wb_rd, i_wb_data);

  // during a memory stall writeback sees bubbles after the first cycle, so the
  // operands forwarded in that first cycle are kept until the stall ends
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stalled_q <= 1'b0;
    end else begin
      stalled_q <= ctrl.hold_back;
    end
  end

  always_ff @(posedge i_clk) begin
    held_a <= op_a;
    held_b <= op_b;
  end

  assign op_a  = stalled_q ? held_a : fwd_a;
  assign op_b  = stalled_q ? held_b : fwd_b;
  assign alu_b = i_id_ex.use_imm ? i_id_ex.imm : op_b;

  always_comb begin
    case (i_id_ex.alu_op)
      ALU_ADD:    alu_y = op_a + alu_b;
      ALU_SUB:    alu_y = op_a - alu_b;
      ALU_AND:    alu_y = op_a & alu_b;
      ALU_OR:     alu_y = op_a | alu_b;
      ALU_XOR:    alu_y = op_a ^ alu_b;
      ALU_SLL:    alu_y = op_a << alu_b[4:0];
      ALU_SRL:    alu_y = op_a >> alu_b[4:0];
      ALU_SRA:    alu_y = word_t'($signed(op_a) >>> alu_b[4:0]);
      ALU_SLT:    alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      ALU_SLTU:   alu_y = {{(XLEN-1){1'b0}}, op_a < alu_b};
      ALU_PASS_B: alu_y = alu_b;
      default:    alu_y = op_a + alu_b;
    endcase
  end

  // branches compare the two register operands, never the immediate
  always_comb begin
    case (i_id_ex.inst[FUNCT3_LSB +: 3])
      F3_BEQ:  cond = op_a == op_b;
      F3_BNE:  cond = op_a != op_b;
      F3_BLT:  cond = $signed(op_a) < $signed(op_b);
      F3_BGE:  cond = $signed(op_a) >= $signed(op_b);
      F3_BLTU: cond = op_a < op_b;
      F3_BGEU: cond = op_a >= op_b;
      default: cond = 1'b0;
    endcase
  end

  // a held branch waits, or the flush would drop it from ID/EX before EX/MEM loads
  assign ctrl.redirect_valid = i_id_ex.valid && i_id_ex.is_branch && cond && !ctrl.hold_back;
  assign ctrl.redirect_pc    = i_id_ex.pc + i_id_ex.imm;

  always_comb begin
    ex_next.inst       = i_id_ex.inst;
    ex_next.pc         = i_id_ex.pc;
    ex_next.valid      = i_id_ex.valid;
    ex_next.alu_result = alu_y;
    ex_next.store_data = op_b;
    ex_next.mem_ren    = i_id_ex.mem_ren;
    ex_next.mem_wen    = i_id_ex.mem_wen;
    ex_next.wb_src     = i_id_ex.wb_src;
    ex_next.rd         = i_id_ex.rd;
  end

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_hold  (ctrl.hold_back),
    .i_flush (1'b0),
    .i_d     (ex_next),
    .o_q     (o_ex_mem)
  );

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
  input  hart_pkg::if_id_t i_if,
  input  hart_pkg::id_ex_t i_id_ex,
  pipe_ctrl_if.hazard      ctrl
);
  import hart_pkg::*;
  import rv_isa_pkg::*;

  reg_addr_t use1;
  reg_addr_t use2;
  logic      load_use;

  assign use1 = src1_addr(i_if.inst);
  assign use2 = src2_addr(i_if.inst);

  // the load result only exists after memory, one cycle too late for execute
  assign load_use = i_if.valid && i_id_ex.valid && i_id_ex.mem_ren && i_id_ex.rd != '0 &&
                    (i_id_ex.rd == use1 || i_id_ex.rd == use2);

  assign ctrl.hold_front  = load_use || ctrl.mem_busy;
  assign ctrl.flush_front = ctrl.redirect_valid;
  // while memory is busy ID/EX is held, and the load-use bubble must not erase it
  assign ctrl.flush_decode = ctrl.redirect_valid || (load_use && !ctrl.mem_busy);
  assign ctrl.hold_back    = ctrl.mem_busy;

endmodule

// File: decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::if_id_t    i_if,
  input  logic                i_wb_wen,
  input  hart_pkg::reg_addr_t i_wb_rd,
  input  hart_pkg::word_t     i_wb_data,
  output hart_pkg::id_ex_t    o_id
);
  import hart_pkg::*;
  import rv_isa_pkg::*;

  // x0 has no storage
  word_t     regs [1:31];
  word_t     inst;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  logic [2:0] f3;

  function automatic alu_op_e alu_decode(logic [2:0] funct3, logic alt);
    case (funct3)
      F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign inst = i_if.inst;
  assign f3   = inst[FUNCT3_LSB +: 3];
  assign rs1  = src1_addr(inst);
  assign rs2  = src2_addr(inst);

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'd0};

  // writeback in the same cycle passes through, so decode never reads a stale value
  assign rs1_val = (rs1 == '0) ? '0 : (i_wb_wen && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (i_wb_wen && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

  always_ff @(posedge i_clk) begin
    if (!i_rst && i_wb_wen && i_wb_rd != '0) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  always_comb begin
    o_id         = '0;
    o_id.pc      = i_if.pc;
    o_id.inst    = inst;
    o_id.valid   = i_if.valid;
    o_id.rs1     = rs1;
    o_id.rs2     = rs2;
    o_id.rs1_val = rs1_val;
    o_id.rs2_val = rs2_val;
    o_id.alu_op  = ALU_ADD;
    o_id.wb_src  = WB_NONE;
    case (opcode_of(inst))
      OPC_OP: begin
        o_id.alu_op = alu_decode(f3, inst[FUNCT7_ALT]);
        o_id.wb_src = WB_ALU;
      end
      OPC_OP_IMM: begin
        // only srai uses the alternate bit, in addi it is part of the immediate
        o_id.alu_op  = alu_decode(f3, f3 == F3_SRL_SRA && inst[FUNCT7_ALT]);
        o_id.use_imm = 1'b1;
        o_id.imm     = imm_i;
        o_id.wb_src  = WB_ALU;
      end
      OPC_LUI: begin
        o_id.alu_op  = ALU_PASS_B;
        o_id.use_imm = 1'b1;
        o_id.imm     = imm_u;
        o_id.wb_src  = WB_ALU;
      end
      OPC_LOAD: begin
        o_id.use_imm = 1'b1;
        o_id.imm     = imm_i;
        o_id.mem_ren = 1'b1;
        o_id.wb_src  = WB_LOAD;
      end
      OPC_STORE: begin
        o_id.use_imm = 1'b1;
        o_id.imm     = imm_s;
        o_id.mem_wen = 1'b1;
      end
      OPC_BRANCH: begin
        o_id.is_branch = 1'b1;
        o_id.imm       = imm_b;
      end
      // ebreak has no effect in the pipe and is only recognized at retire
      default: o_id.wb_src = WB_NONE;
    endcase
    o_id.rd = (o_id.wb_src != WB_NONE) ? inst[RD_LSB +: 5] : '0;
  end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic             i_clk,
  input  logic             i_rst,
  pipe_ctrl_if.fetch       ctrl,
  input  hart_pkg::word_t  i_imem_rdata,
  output hart_pkg::word_t  o_imem_raddr,
  output hart_pkg::if_id_t o_if
);
  import hart_pkg::*;

  word_t pc_q;

  // a taken branch overrides a stall, since the stalled fetch is discarded anyway
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= RESET_ADDR;
    end else if (ctrl.redirect_valid) begin
      pc_q <= ctrl.redirect_pc;
    end else if (!ctrl.hold_front) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // instruction memory answers in the same cycle, so the word pairs with pc_q
  assign o_imem_raddr = pc_q;

  always_comb begin
    o_if.pc    = pc_q;
    o_if.inst  = i_imem_rdata;
    o_if.valid = 1'b1;
  end

endmodule

// File: pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
  parameter type payload_t = hart_pkg::if_id_t
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_hold,
  input  logic     i_flush,
  input  payload_t i_d,
  output payload_t o_q
);

  // flush wins over hold, so a stalled stage can still be turned into a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      o_q <= '0;
    end else if (!i_hold) begin
      o_q <= i_d;
    end
  end

  // a flushed instruction must never reach the next stage, whatever the hold state
  a_flush_kills: assert property (@(posedge i_clk) disable iff (i_rst)
    i_flush |=> !o_q.valid);

endmodule

// File: pipe_ctrl_if.sv
`timescale 1ns/1ns

// stall, flush and redirect traffic shared by the pipeline stages
interface pipe_ctrl_if;
  import hart_pkg::*;

  logic  mem_busy;
  logic  redirect_valid;
  word_t redirect_pc;
  // front covers the pc and IF/ID, back covers ID/EX and EX/MEM
  logic  hold_front;
  logic  flush_front;
  logic  flush_decode;
  logic  hold_back;

  modport hazard (
    input  mem_busy,
    input  redirect_valid,
    output hold_front,
    output flush_front,
    output flush_decode,
    output hold_back
  );
  modport fetch (input redirect_valid, input redirect_pc, input hold_front);
  modport execute (input hold_back, output redirect_valid, output redirect_pc);
  modport memory (output mem_busy);
endinterface

// File: hart_pkg.sv
package hart_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // pass-b carries the u-immediate straight through for lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_LOAD
  } wb_src_e;

  typedef struct packed {
    word_t pc;
    word_t inst;
    logic  valid;
  } if_id_t;

  // rd is zero for every instruction that does not write a register
  typedef struct packed {
    word_t     pc;
    word_t     inst;
    logic      valid;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      is_branch;
    logic      mem_ren;
    logic      mem_wen;
    wb_src_e   wb_src;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    word_t     inst;
    word_t     pc;
    logic      valid;
    word_t     alu_result;
    word_t     store_data;
    logic      mem_ren;
    logic      mem_wen;
    wb_src_e   wb_src;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    word_t     inst;
    word_t     pc;
    logic      valid;
    word_t     alu_result;
    word_t     load_data;
    wb_src_e   wb_src;
    reg_addr_t rd;
  } mem_wb_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the RV32I subset this core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 of the register and immediate ALU forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // low bit of each instruction field
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;

  // instruction bit that turns add into sub and srl into sra
  localparam int FUNCT7_ALT = 30;

  localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

  function automatic opcode_e opcode_of(logic [31:0] inst);
    return opcode_e'(inst[6:0]);
  endfunction

  // source addresses, forced to x0 for formats without that source so
  // that hazard and forwarding compares can never hit on them
  function automatic logic [4:0] src1_addr(logic [31:0] inst);
    if (opcode_of(inst) inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH}) begin
      return inst[RS1_LSB +: 5];
    end
    return 5'd0;
  endfunction

  function automatic logic [4:0] src2_addr(logic [31:0] inst);
    if (opcode_of(inst) inside {OPC_OP, OPC_STORE, OPC_BRANCH}) begin
      return inst[RS2_LSB +: 5];
    end
    return 5'd0;
  endfunction

endpackage
